//--- compile.f
hdl/dlxIsaPkg.sv
hdl/dlxCtrlPkg.sv
hdl/instrDecoder.sv
hdl/executeStage.sv
hdl/retireStage.sv
hdl/controlPipeline.sv
verification/controlPipelineTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = controlPipelineTb
FILELIST = compile.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILDDIR)

run: compile
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

//--- verification/controlPipelineTb.sv
// Testbench for the DLX control pipeline. Directed instruction classes and forwarding
// cases, then a random stream with gaps and output stalls, all checked in order
// against a reference decode and forwarding model.

`timescale 1ns/1ps
`default_nettype none

module controlPipelineTb;
	import dlxIsaPkg::*;
	import dlxCtrlPkg::*;

	logic clk;
	logic rstN;
	logic inValid;
	wordT instr;
	logic inReady;
	retireT outRecord;
	logic outValid;
	logic outReady;

	logic [15:0] lfsr = 16'd36268;
	logic stallsOn = 1'b0; // Random outReady when set
	logic offerTaken = 1'b0; // Offered word enters decode at the coming edge
	regIdxT nearDest = zeroReg; // destReg of the slot entered one edge earlier
	regIdxT farDest = zeroReg;
	retireT expectQ [$];
	wordT stimWords [$];
	int stimGaps [$];
	logic [opcodeW-1:0] keptOps [27];
	logic [funcW-1:0] keptFuncs [16];
	int errorCount = 0;
	int recvCount = 0;
	int cycleCount = 0;
	int cycleLimit = 0;

	controlPipeline dut_i
	(
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.instr(instr),
		.inReady(inReady),
		.out(outRecord),
		.outValid(outValid),
		.outReady(outReady)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	//**********************************************************
	// Stimulus helpers
	//**********************************************************
	// 16-bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [31:0] randBits(input int count);
		logic [31:0] bits;
		logic feedback;
		int i;
		bits = '0;
		for (i = 0; i < count; i++)
		begin
			feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], feedback};
			bits = {bits[30:0], feedback};
		end
		return bits;
	endfunction

	function automatic wordT rType(input logic [funcW-1:0] fn, input regIdxT rs1,
		input regIdxT rs2, input regIdxT rd);
		return {opSpecial, rs1, rs2, rd, 5'd0, fn};
	endfunction

	function automatic wordT iType(input logic [opcodeW-1:0] op, input regIdxT rs1,
		input regIdxT rs2, input logic [15:0] imm);
		return {op, rs1, rs2, imm};
	endfunction

	function automatic wordT randomWord();
		int pick;
		regIdxT rs1;
		regIdxT rs2;
		regIdxT rd;
		pick = int'(randBits(6) % 32'd43);
		rs1 = regIdxT'(randBits(3)); // r0..r7 keeps dependencies frequent
		rs2 = regIdxT'(randBits(3));
		rd = regIdxT'(randBits(3));
		if (pick < 16)
			return rType(keptFuncs[pick], rs1, rs2, rd);
		return iType(keptOps[pick - 16], rs1, rs2, 16'(randBits(16)));
	endfunction

	task automatic addWord(input wordT word, input int gap);
		stimWords.push_back(word);
		stimGaps.push_back(gap);
	endtask

	task automatic driveCycle(input logic valid, input wordT word);
		@(negedge clk);
		inValid = valid;
		instr = word;
		outReady = stallsOn ? (randBits(2) != 32'd0) : 1'b1;
	endtask

	// Holds the word on instr until it is accepted
	task automatic sendWord(input wordT word);
		driveCycle(1'b1, word);
		@(posedge clk);
		while (!offerTaken)
		begin
			driveCycle(1'b1, word);
			@(posedge clk);
		end
	endtask

	//**********************************************************
	// Reference model
	//**********************************************************
	function automatic operandSelT operandSource(input regIdxT readReg, input regIdxT near,
		input regIdxT far);
		operandSelT sel;
		sel = selRegFile;
		if (readReg == far)
			sel = selFromWb;
		if (readReg == near)
			sel = selFromMem; // Younger producer overrides
		if (readReg == zeroReg)
			sel = selZero;
		return sel;
	endfunction

	function automatic retireT expectRecord(input wordT word, input regIdxT near,
		input regIdxT far);
		logic [5:0] op;
		logic [5:0] code;
		logic known;
		logic isLoad;
		logic isStore;
		logic isImm;
		regIdxT srcReg;
		regIdxT tgtReg;
		retireT e;
		op = word[31:26];
		e = '0;
		srcReg = zeroReg;
		tgtReg = zeroReg;
		known = 1'b1;
		code = 6'h3F; // No ALU row
		isLoad = op inside {opLb, opLh, opLw, opLbu, opLhu};
		isStore = op inside {opSb, opSh, opSw};
		// Immediate forms reuse the row of their register form
		case (op)
			opSpecial: code = word[5:0];
			opAddi, opAddui: code = funcAdd;
			opSubi, opSubui: code = funcSub;
			opAndi: code = funcAnd;
			opOri: code = funcOr;
			opXori: code = funcXor;
			opSlli: code = funcSll;
			opSrli: code = funcSrl;
			opSrai: code = funcSra;
			opSeqi: code = funcSeq;
			opSnei: code = funcSne;
			opSlti: code = funcSlt;
			opSgti: code = funcSgt;
			opSlei: code = funcSle;
			opSgei: code = funcSge;
			default: code = 6'h3F;
		endcase
		case (code)
			funcAdd, funcAddu: e.aluOp = aluAdd;
			funcSub, funcSubu: e.aluOp = aluSub;
			funcAnd: e.aluOp = aluAnd;
			funcOr: e.aluOp = aluOr;
			funcXor: e.aluOp = aluXor;
			funcSll: e.resultSel = resShiftLeft;
			funcSrl: e.resultSel = resShiftRightLogic;
			funcSra: e.resultSel = resShiftRightArith;
			funcSeq: e.cmpCond = cmpEq;
			funcSne: e.cmpCond = cmpNe;
			funcSlt: e.cmpCond = cmpLt;
			funcSgt: e.cmpCond = cmpGt;
			funcSle: e.cmpCond = cmpLe;
			funcSge: e.cmpCond = cmpGe;
			default: known = 1'b0;
		endcase
		if (code inside {funcSeq, funcSne, funcSlt, funcSgt, funcSle, funcSge})
		begin
			e.aluOp = aluSub;
			e.resultSel = resCompare;
		end
		isImm = (op != opSpecial && known) || op == opLhi || isLoad;
		if (op == opSpecial && known)
		begin
			srcReg = word[25:21];
			tgtReg = word[20:16];
			e.writeEnable = 1'b1;
			e.destReg = word[15:11];
		end
		else if (isImm)
		begin
			srcReg = (op == opLhi) ? zeroReg : word[25:21];
			e.writeEnable = 1'b1;
			e.destReg = word[20:16];
		end
		if (op == opLhi)
			e.resultSel = resLoadHigh;
		if (isLoad)
		begin
			e.memRead = 1'b1;
			e.wbFromMem = 1'b1;
		end
		if (isStore)
		begin
			srcReg = word[25:21];
			tgtReg = word[20:16];
			e.memWrite = 1'b1;
		end
		if (op == opJal || op == opJalr)
		begin
			e.aluOp = aluPassLink;
			e.writeEnable = 1'b1;
			e.destReg = linkReg;
		end
		e.srcSel = operandSource(srcReg, near, far);
		e.tgtSel = isImm ? selImmediate : operandSource(tgtReg, near, far);
		return e;
	endfunction

	//**********************************************************
	// Checking
	//**********************************************************
	task automatic reportMismatch(input string field, input int got, input int want);
		$display("FAIL %0t: record %0d field %s is %0d, expected %0d", $time, recvCount,
			field, got, want);
		errorCount++;
	endtask

	task automatic compareRecord(input retireT got, input retireT want);
		if (got.aluOp !== want.aluOp)
			reportMismatch("aluOp", int'(got.aluOp), int'(want.aluOp));
		if (got.resultSel !== want.resultSel)
			reportMismatch("resultSel", int'(got.resultSel), int'(want.resultSel));
		if (got.cmpCond !== want.cmpCond)
			reportMismatch("cmpCond", int'(got.cmpCond), int'(want.cmpCond));
		if (got.srcSel !== want.srcSel)
			reportMismatch("srcSel", int'(got.srcSel), int'(want.srcSel));
		if (got.tgtSel !== want.tgtSel)
			reportMismatch("tgtSel", int'(got.tgtSel), int'(want.tgtSel));
		if (got.memRead !== want.memRead)
			reportMismatch("memRead", int'(got.memRead), int'(want.memRead));
		if (got.memWrite !== want.memWrite)
			reportMismatch("memWrite", int'(got.memWrite), int'(want.memWrite));
		if (got.writeEnable !== want.writeEnable)
			reportMismatch("writeEnable", int'(got.writeEnable), int'(want.writeEnable));
		if (got.wbFromMem !== want.wbFromMem)
			reportMismatch("wbFromMem", int'(got.wbFromMem), int'(want.wbFromMem));
		if (got.destReg !== want.destReg)
			reportMismatch("destReg", int'(got.destReg), int'(want.destReg));
	endtask

	// Slot log, sampled 2 ns before each rising edge
	initial
	begin : logSlots
		retireT entered;
		forever
		begin
			@(negedge clk);
			#8;
			offerTaken = rstN && inValid && inReady;
			if (rstN && outValid && !outReady && inReady)
			begin
				$display("FAIL %0t: inReady high while the output is stalled", $time);
				errorCount++;
			end
			if (rstN && inReady)
			begin
				entered = '0; // Bubble writes nothing
				if (inValid)
				begin
					entered = expectRecord(instr, nearDest, farDest);
					expectQ.push_back(entered);
				end
				farDest = nearDest;
				nearDest = entered.destReg;
			end
		end
	end

	initial
	begin : compareOutput
		retireT want;
		forever
		begin
			@(negedge clk);
			#8;
			if (rstN && outValid && outReady)
			begin
				if (expectQ.size() == 0)
				begin
					$display("Output record at %0t arrived with nothing outstanding", $time);
					errorCount++;
				end
				else
				begin
					want = expectQ.pop_front();
					compareRecord(outRecord, want);
					recvCount++;
				end
			end
		end
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount > cycleLimit)
		begin
			$display("Timeout after %0d cycles with %0d records outstanding", cycleCount,
				expectQ.size());
			$display("test failed");
			$finish;
		end
	end

	//**********************************************************
	// Main sequence
	//**********************************************************
	initial
	begin : mainSequence
		int n;
		int gap;
		int stallFrom;
		rstN = 1'b0;
		inValid = 1'b0;
		instr = '0;
		outReady = 1'b0;
		keptFuncs = '{funcAdd, funcAddu, funcSub, funcSubu, funcAnd, funcOr, funcXor,
			funcSll, funcSrl, funcSra, funcSeq, funcSne, funcSlt, funcSgt, funcSle, funcSge};
		keptOps = '{opJal, opJalr, opAddi, opAddui, opSubi, opSubui, opAndi, opOri, opXori,
			opLhi, opSlli, opSrli, opSrai, opSeqi, opSnei, opSlti, opSgti, opSlei, opSgei,
			opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw};

		// Every class alone, two bubbles apart
		foreach (keptFuncs[i])
			addWord(rType(keptFuncs[i], 5'd1, 5'd2, 5'd3), 2);
		foreach (keptOps[i])
			addWord(iType(keptOps[i], 5'd4, 5'd5, 16'h1234), 2);
		addWord(iType(6'h3F, 5'd6, 5'd7, 16'h0000), 2); // Unsupported opcode
		addWord(rType(6'h3F, 5'd6, 5'd7, 5'd8), 2); // Unsupported function

		// Back to back, and writes to r0 never forwarded
		addWord(rType(funcAdd, 5'd1, 5'd2, 5'd5), 2);
		addWord(rType(funcSub, 5'd5, 5'd5, 5'd6), 0);
		addWord(iType(opAddi, 5'd1, 5'd0, 16'h0007), 0);
		addWord(rType(funcOr, 5'd0, 5'd0, 5'd7), 0);
		addWord(rType(funcXor, 5'd6, 5'd0, 5'd8), 0);

		// One bubble, two bubbles, then a store ahead of a reader of its field bits
		addWord(rType(funcAnd, 5'd1, 5'd2, 5'd10), 2);
		addWord(rType(funcAdd, 5'd10, 5'd10, 5'd11), 1);
		addWord(iType(opLw, 5'd11, 5'd12, 16'h0010), 2);
		addWord(iType(opSw, 5'd12, 5'd12, 16'h8800), 0); // Bits 15:11 hold 17
		addWord(rType(funcAdd, 5'd17, 5'd12, 5'd13), 0);

		stallFrom = stimWords.size();
		for (n = 0; n < 200; n++)
		begin
			gap = (randBits(2) == 32'd0) ? int'(randBits(2)) : 0;
			addWord(randomWord(), gap);
		end
		cycleLimit = 40 + 12 * stimWords.size();

		repeat (10) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		#8;
		if (outValid !== 1'b0 || inReady !== 1'b1)
		begin
			$display("FAIL %0t: after reset outValid is %b and inReady is %b", $time,
				outValid, inReady);
			errorCount++;
		end

		for (n = 0; n < stimWords.size(); n++)
		begin
			if (n == stallFrom)
				stallsOn = 1'b1;
			repeat (stimGaps[n]) driveCycle(1'b0, randomWord()); // Bubble carries a stray word
			sendWord(stimWords[n]);
		end
		while (expectQ.size() != 0)
			driveCycle(1'b0, '0);
		repeat (4) driveCycle(1'b0, '0); // Catch duplicated records

		if (recvCount != stimWords.size())
		begin
			$display("Received %0d records for %0d instructions", recvCount,
				stimWords.size());
			errorCount++;
		end
		$display("Records checked %0d, errors %0d", recvCount, errorCount);
		if (errorCount == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/controlPipeline.sv
// Top level of the DLX control pipeline: decode, execute, memory and writeback slots
// between a valid/ready instruction input and a valid/ready control record output.

`timescale 1ns/1ps
`default_nettype none

module controlPipeline
(
	input logic clk,
	input logic rstN,
	input logic inValid,
	input dlxIsaPkg::wordT instr,
	output logic inReady,
	output dlxCtrlPkg::retireT out,
	output logic outValid,
	input logic outReady
);
	import dlxIsaPkg::*;
	import dlxCtrlPkg::*;

	logic advance;
	decodedT decSlot;
	logic decValid;
	retireT exSlot;
	logic exValid;
	regIdxT memDest;

	assign inReady = advance; // One shift enable for all slots

	instrDecoder decoder_i
	(
		.clk(clk),
		.rstN(rstN),
		.advance(advance),
		.inValid(inValid),
		.instr(instr),
		.decSlot(decSlot),
		.decValid(decValid)
	);

	executeStage execute_i
	(
		.clk(clk),
		.rstN(rstN),
		.advance(advance),
		.decSlot(decSlot),
		.decValid(decValid),
		.memDest(memDest),
		.exSlot(exSlot),
		.exValid(exValid)
	);

	retireStage retire_i
	(
		.clk(clk),
		.rstN(rstN),
		.exSlot(exSlot),
		.exValid(exValid),
		.outReady(outReady),
		.memDest(memDest),
		.advance(advance),
		.out(out),
		.outValid(outValid)
	);

endmodule

`default_nettype wire

//--- hdl/retireStage.sv
// Memory and writeback slots. The writeback slot is the pipeline output, and its
// occupancy with outReady decides whether all slots advance.

`timescale 1ns/1ps
`default_nettype none

module retireStage
(
	input logic clk,
	input logic rstN,
	input dlxCtrlPkg::retireT exSlot,
	input logic exValid,
	input logic outReady,
	output dlxIsaPkg::regIdxT memDest,
	output logic advance,
	output dlxCtrlPkg::retireT out,
	output logic outValid
);
	import dlxIsaPkg::*;
	import dlxCtrlPkg::*;

	retireT memSlot;
	logic memValid;

	// Empty writeback slot lets a bubble be squeezed out under stall
	assign advance = outReady || !outValid;
	assign memDest = memValid ? memSlot.destReg : zeroReg; // destReg already zero if no write

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			memValid <= 1'b0;
			outValid <= 1'b0;
		end
		else if (advance)
		begin
			memValid <= exValid;
			outValid <= memValid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			memSlot <= exSlot;
			out <= memSlot;
		end
	end

endmodule

`default_nettype wire

//--- hdl/executeStage.sv
// Execute slot: picks the operand sources against the two instructions ahead
// and holds the resulting retire record.

`timescale 1ns/1ps
`default_nettype none

module executeStage
(
	input logic clk,
	input logic rstN,
	input logic advance,
	input dlxCtrlPkg::decodedT decSlot,
	input logic decValid,
	input dlxIsaPkg::regIdxT memDest,
	output dlxCtrlPkg::retireT exSlot,
	output logic exValid
);
	import dlxIsaPkg::*;
	import dlxCtrlPkg::*;

	regIdxT exDest;
	retireT exNext;

	// Register 0 is never forwarded; the nearer producer wins
	function automatic operandSelT forwardSel(regIdxT readReg, regIdxT nearDest,
		regIdxT farDest);
		if (readReg == zeroReg)
			return selZero;
		else if (readReg == nearDest)
			return selFromMem;
		else if (readReg == farDest)
			return selFromWb;
		else
			return selRegFile;
	endfunction

	assign exDest = exValid ? exSlot.destReg : zeroReg;

	always_comb
	begin
		exNext.aluOp = decSlot.aluOp;
		exNext.resultSel = decSlot.resultSel;
		exNext.cmpCond = decSlot.cmpCond;
		exNext.srcSel = forwardSel(decSlot.srcReg, exDest, memDest);
		exNext.tgtSel = decSlot.usesImm ? selImmediate :
			forwardSel(decSlot.tgtReg, exDest, memDest);
		exNext.memRead = decSlot.memRead;
		exNext.memWrite = decSlot.memWrite;
		exNext.writeEnable = decSlot.writeEnable;
		exNext.wbFromMem = decSlot.wbFromMem;
		exNext.destReg = decSlot.destReg;
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			exValid <= 1'b0;
		else if (advance)
			exValid <= decValid;
	end

	always_ff @(posedge clk)
	begin
		if (advance)
			exSlot <= exNext;
	end

endmodule

`default_nettype wire

//--- hdl/instrDecoder.sv
// Decode slot: maps an accepted instruction word to its control record once,
// then holds it until the pipeline advances.

`timescale 1ns/1ps
`default_nettype none

module instrDecoder
(
	input logic clk,
	input logic rstN,
	input logic advance,
	input logic inValid,
	input dlxIsaPkg::wordT instr,
	output dlxCtrlPkg::decodedT decSlot,
	output logic decValid
);
	import dlxIsaPkg::*;
	import dlxCtrlPkg::*;

	logic [opcodeW-1:0] opcode;
	logic [funcW-1:0] func;
	regIdxT rs1;
	regIdxT rs2;
	regIdxT rd;
	decodedT decNext;
	logic regForm; // Reads rs1 and rs2, writes rd
	logic immForm; // Reads rs1 and the immediate, writes rs2

	assign opcode = instr[opcodeLsb +: opcodeW];
	assign func = instr[funcLsb +: funcW];
	assign rs1 = instr[rs1Lsb +: regIdxW];
	assign rs2 = instr[rs2Lsb +: regIdxW];
	assign rd = instr[rdLsb +: regIdxW];

	//**********************************************************
	// Decode table
	//**********************************************************
	always_comb
	begin
		decNext = '0; // No-op unless a row below matches
		regForm = 1'b0;
		immForm = 1'b1;
		case (opcode)
			opSpecial:
			begin
				immForm = 1'b0;
				regForm = 1'b1;
				case (func)
					funcAdd, funcAddu: decNext.aluOp = aluAdd;
					funcSub, funcSubu: decNext.aluOp = aluSub;
					funcAnd: decNext.aluOp = aluAnd;
					funcOr: decNext.aluOp = aluOr;
					funcXor: decNext.aluOp = aluXor;
					funcSll: decNext.resultSel = resShiftLeft;
					funcSrl: decNext.resultSel = resShiftRightLogic;
					funcSra: decNext.resultSel = resShiftRightArith;
					funcSeq, funcSne, funcSlt, funcSgt, funcSle, funcSge:
					begin
						decNext.aluOp = aluSub;
						decNext.resultSel = resCompare;
						decNext.cmpCond = cmpCondT'(func[2:0]);
					end
					default: regForm = 1'b0;
				endcase
			end
			opJal, opJalr:
			begin
				immForm = 1'b0;
				decNext.aluOp = aluPassLink;
				decNext.writeEnable = 1'b1;
				decNext.destReg = linkReg;
			end
			opSb, opSh, opSw:
			begin
				immForm = 1'b0;
				decNext.srcReg = rs1; // Base address
				decNext.tgtReg = rs2; // Store data
				decNext.memWrite = 1'b1;
			end
			opAddi, opAddui: decNext.aluOp = aluAdd;
			opSubi, opSubui: decNext.aluOp = aluSub;
			opAndi: decNext.aluOp = aluAnd;
			opOri: decNext.aluOp = aluOr;
			opXori: decNext.aluOp = aluXor;
			opSlli: decNext.resultSel = resShiftLeft;
			opSrli: decNext.resultSel = resShiftRightLogic;
			opSrai: decNext.resultSel = resShiftRightArith;
			opLhi: decNext.resultSel = resLoadHigh;
			opSeqi, opSnei, opSlti, opSgti, opSlei, opSgei:
			begin
				decNext.aluOp = aluSub;
				decNext.resultSel = resCompare;
				decNext.cmpCond = cmpCondT'(opcode[2:0]);
			end
			opLb, opLh, opLw, opLbu, opLhu:
			begin
				decNext.memRead = 1'b1;
				decNext.wbFromMem = 1'b1;
			end
			default: immForm = 1'b0;
		endcase

		if (regForm)
		begin
			decNext.srcReg = rs1;
			decNext.tgtReg = rs2;
			decNext.writeEnable = 1'b1;
			decNext.destReg = rd;
		end
		if (immForm)
		begin
			decNext.srcReg = (opcode == opLhi) ? zeroReg : rs1; // LHI reads no register
			decNext.usesImm = 1'b1;
			decNext.writeEnable = 1'b1;
			decNext.destReg = rs2;
		end
	end

	//**********************************************************
	// Decode slot
	//**********************************************************
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			decValid <= 1'b0;
		else if (advance)
			decValid <= inValid; // Bubble when nothing is offered
	end

	always_ff @(posedge clk)
	begin
		if (advance)
			decSlot <= decNext;
	end

endmodule

`default_nettype wire

//--- hdl/dlxCtrlPkg.sv
// Control record types carried down the pipeline slots, with the select encodings
// for ALU operation, result source, compare condition and operand source.

`default_nettype none

package dlxCtrlPkg;

	typedef enum logic [2:0]
	{
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluPassLink // Link address straight to the result
	} aluOpT;

	typedef enum logic [2:0]
	{
		resAlu,
		resShiftLeft,
		resShiftRightLogic,
		resShiftRightArith,
		resCompare,
		resLoadHigh
	} resultSelT;

	// Order follows the low three bits of the set-compare codes
	typedef enum logic [2:0]
	{
		cmpEq = 3'd0,
		cmpNe = 3'd1,
		cmpLt = 3'd2,
		cmpGt = 3'd3,
		cmpLe = 3'd4,
		cmpGe = 3'd5
	} cmpCondT;

	typedef enum logic [2:0]
	{
		selFromWb,
		selRegFile,
		selFromMem,
		selZero,
		selImmediate
	} operandSelT;

	//**********************************************************
	// Stage records
	//**********************************************************
	typedef struct packed
	{
		aluOpT aluOp;
		resultSelT resultSel;
		cmpCondT cmpCond;
		dlxIsaPkg::regIdxT srcReg; // Zero when rs1 is not read
		dlxIsaPkg::regIdxT tgtReg; // Zero when rs2 is not read
		logic usesImm;
		logic memRead;
		logic memWrite;
		logic writeEnable;
		logic wbFromMem;
		dlxIsaPkg::regIdxT destReg; // Zero when nothing is written
	} decodedT;

	typedef struct packed
	{
		aluOpT aluOp;
		resultSelT resultSel;
		cmpCondT cmpCond;
		operandSelT srcSel;
		operandSelT tgtSel;
		logic memRead;
		logic memWrite;
		logic writeEnable;
		logic wbFromMem;
		dlxIsaPkg::regIdxT destReg;
	} retireT;

endpackage

`default_nettype wire

//--- hdl/dlxIsaPkg.sv
// DLX instruction set constants: word and field layout, opcodes and function codes.
// Imported by the decode and forwarding logic of the control pipeline.

`default_nettype none

package dlxIsaPkg;

	//**********************************************************
	// Word and field layout
	//**********************************************************
	localparam int wordW = 32;
	localparam int regIdxW = 5;
	localparam int opcodeW = 6;
	localparam int funcW = 6;

	localparam int opcodeLsb = 26;
	localparam int rs1Lsb = 21;
	localparam int rs2Lsb = 16;
	localparam int rdLsb = 11;
	localparam int funcLsb = 0;

	typedef logic [wordW-1:0] wordT;
	typedef logic [regIdxW-1:0] regIdxT;

	localparam regIdxT zeroReg = 5'd0;
	localparam regIdxT linkReg = 5'd31; // Return address of JAL and JALR

	//**********************************************************
	// Primary opcodes
	//**********************************************************
	localparam logic [opcodeW-1:0] opSpecial = 6'h00; // R-type, decoded by func
	localparam logic [opcodeW-1:0] opJal = 6'h03;
	localparam logic [opcodeW-1:0] opAddi = 6'h08;
	localparam logic [opcodeW-1:0] opAddui = 6'h09;
	localparam logic [opcodeW-1:0] opSubi = 6'h0A;
	localparam logic [opcodeW-1:0] opSubui = 6'h0B;
	localparam logic [opcodeW-1:0] opAndi = 6'h0C;
	localparam logic [opcodeW-1:0] opOri = 6'h0D;
	localparam logic [opcodeW-1:0] opXori = 6'h0E;
	localparam logic [opcodeW-1:0] opLhi = 6'h0F;
	localparam logic [opcodeW-1:0] opJalr = 6'h13;
	localparam logic [opcodeW-1:0] opSlli = 6'h14;
	localparam logic [opcodeW-1:0] opSrli = 6'h16;
	localparam logic [opcodeW-1:0] opSrai = 6'h17;
	localparam logic [opcodeW-1:0] opSeqi = 6'h18; // Set-compares 18..1D, low bits give condition
	localparam logic [opcodeW-1:0] opSnei = 6'h19;
	localparam logic [opcodeW-1:0] opSlti = 6'h1A;
	localparam logic [opcodeW-1:0] opSgti = 6'h1B;
	localparam logic [opcodeW-1:0] opSlei = 6'h1C;
	localparam logic [opcodeW-1:0] opSgei = 6'h1D;
	localparam logic [opcodeW-1:0] opLb = 6'h20;
	localparam logic [opcodeW-1:0] opLh = 6'h21;
	localparam logic [opcodeW-1:0] opLw = 6'h23;
	localparam logic [opcodeW-1:0] opLbu = 6'h24;
	localparam logic [opcodeW-1:0] opLhu = 6'h25;
	localparam logic [opcodeW-1:0] opSb = 6'h28;
	localparam logic [opcodeW-1:0] opSh = 6'h29;
	localparam logic [opcodeW-1:0] opSw = 6'h2B;

	//**********************************************************
	// Function codes under opSpecial
	//**********************************************************
	localparam logic [funcW-1:0] funcSll = 6'h04;
	localparam logic [funcW-1:0] funcSrl = 6'h06;
	localparam logic [funcW-1:0] funcSra = 6'h07;
	localparam logic [funcW-1:0] funcAdd = 6'h20;
	localparam logic [funcW-1:0] funcAddu = 6'h21;
	localparam logic [funcW-1:0] funcSub = 6'h22;
	localparam logic [funcW-1:0] funcSubu = 6'h23;
	localparam logic [funcW-1:0] funcAnd = 6'h24;
	localparam logic [funcW-1:0] funcOr = 6'h25;
	localparam logic [funcW-1:0] funcXor = 6'h26;
	localparam logic [funcW-1:0] funcSeq = 6'h28;
	localparam logic [funcW-1:0] funcSne = 6'h29;
	localparam logic [funcW-1:0] funcSlt = 6'h2A;
	localparam logic [funcW-1:0] funcSgt = 6'h2B;
	localparam logic [funcW-1:0] funcSle = 6'h2C;
	localparam logic [funcW-1:0] funcSge = 6'h2D;

endpackage

`default_nettype wire
